/* core_pkg.sv */
package core_pkg;

  // ======================================================================
  // Widths
  // ======================================================================

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  typedef logic [31:0]          inst_t;
  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // ======================================================================
  // Instruction encodings
  // ======================================================================

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 for register-register ops; ALT selects SUB
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  // ======================================================================
  // Stage records
  // ======================================================================

  typedef struct packed {
    alu_op_e  alu_op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     use_imm;
    word_t    imm;
    logic     rd_we;
    logic     illegal;
  } decoded_t;

  typedef struct packed {
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
  } id_ex_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    result;
    logic     we;
    logic     illegal;
  } commit_t;

endpackage

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  core_pkg::inst_t    inst_i,
  output core_pkg::decoded_t dec_o
);
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  alu_op_e    f3_op;
  logic       f3_ok;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  // I-type sign-extended, U-type upper 20 bits
  assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};

  // funct3 mapping common to OP and OP-IMM; shifts are not supported
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      F3_ADD:  f3_op = ALU_ADD;
      F3_SLT:  f3_op = ALU_SLT;
      F3_SLTU: f3_op = ALU_SLTU;
      F3_XOR:  f3_op = ALU_XOR;
      F3_OR:   f3_op = ALU_OR;
      F3_AND:  f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec_o         = '0;
    dec_o.alu_op  = ALU_ADD;
    dec_o.rs1     = inst_i[19:15];
    dec_o.rs2     = inst_i[24:20];
    dec_o.rd      = inst_i[11:7];

    case (opcode)
      OPC_OP: begin
        dec_o.rd_we = 1'b1;
        if (funct7 == F7_BASE) begin
          dec_o.alu_op  = f3_op;
          dec_o.illegal = !f3_ok;
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          dec_o.alu_op = ALU_SUB;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec_o.rd_we   = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_i;
        dec_o.alu_op  = f3_op;
        dec_o.illegal = !f3_ok;
      end
      OPC_LUI: begin
        dec_o.rd_we   = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_u;
        dec_o.alu_op  = ALU_PASS_B;
      end
      default: begin
        dec_o.illegal = 1'b1;
      end
    endcase

    // Decode error must not touch the register file
    if (dec_o.illegal) begin
      dec_o.rd_we = 1'b0;
    end
  end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::reg_idx_t rs1_idx_i,
  input  core_pkg::reg_idx_t rs2_idx_i,
  output core_pkg::word_t    rs1_data_o,
  output core_pkg::word_t    rs2_data_o,
  input  logic               we_i,
  input  core_pkg::reg_idx_t rd_idx_i,
  input  core_pkg::word_t    rd_data_i
);
  import core_pkg::*;

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  function automatic word_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we_i && idx == rd_idx_i) begin
      return rd_data_i;  // write-through
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_idx_i != '0) begin
      regs[rd_idx_i] <= rd_data_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_idx_i);
    rs2_data_o = read_port(rs2_idx_i);
  end

endmodule

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
  input  core_pkg::id_ex_t  id_ex_i,
  input  logic              wb_valid_i,
  input  core_pkg::commit_t wb_i,
  output core_pkg::commit_t ex_o
);
  import core_pkg::*;

  decoded_t dec;
  logic     wb_hit;
  logic     fwd_a;
  logic     fwd_b;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    op_a;
  word_t    op_b;
  word_t    result;

  assign dec = id_ex_i.dec;

  // ======================================================================
  // Operand forwarding from the writeback stage
  // ======================================================================

  assign wb_hit = wb_valid_i && wb_i.we && (wb_i.rd != '0);
  assign fwd_a  = wb_hit && (wb_i.rd == dec.rs1);
  assign fwd_b  = wb_hit && (wb_i.rd == dec.rs2);

  assign rs1_val = fwd_a ? wb_i.result : id_ex_i.rs1_data;
  assign rs2_val = fwd_b ? wb_i.result : id_ex_i.rs2_data;

  assign op_a = rs1_val;
  assign op_b = dec.use_imm ? dec.imm : rs2_val;

  // ======================================================================
  // ALU
  // ======================================================================

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_OR:     result = op_a | op_b;
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SLT: begin
        result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      ALU_SLTU: begin
        result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
      end
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // Writeback record
  always_comb begin
    ex_o.rd      = dec.rd;
    ex_o.result  = result;
    ex_o.we      = dec.rd_we;
    ex_o.illegal = dec.illegal;
  end

endmodule

/* int_pipeline.sv */
`timescale 1ns/1ps

module int_pipeline (
  input  logic              clk_i,
  input  logic              rst_i,
  // Instruction stream
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  core_pkg::inst_t   in_inst_i,
  // Commit stream
  output logic              commit_valid_o,
  input  logic              commit_ready_i,
  output core_pkg::commit_t commit_o
);
  import core_pkg::*;

  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  id_ex_t   id_ex_d;
  id_ex_t   id_ex_q;
  logic     id_ex_valid;
  logic     ex_wb_ready;
  commit_t  ex_rec;
  logic     rf_we;

  // ======================================================================
  // Decode and register read
  // ======================================================================

  inst_decoder u_decoder (
    .inst_i (in_inst_i),
    .dec_o  (dec)
  );

  // Write happens on the commit handshake only, never to x0
  assign rf_we = commit_valid_o && commit_ready_i && commit_o.we && (commit_o.rd != '0);

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_idx_i  (dec.rs1),
    .rs2_idx_i  (dec.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_idx_i   (commit_o.rd),
    .rd_data_i  (commit_o.result)
  );

  assign id_ex_d.dec      = dec;
  assign id_ex_d.rs1_data = rs1_data;
  assign id_ex_d.rs2_data = rs2_data;

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (id_ex_d),
    .valid_o (id_ex_valid),
    .ready_i (ex_wb_ready),
    .data_o  (id_ex_q)
  );

  // ======================================================================
  // Execute and writeback
  // ======================================================================

  exec_stage u_exec (
    .id_ex_i    (id_ex_q),
    .wb_valid_i (commit_valid_o),
    .wb_i       (commit_o),
    .ex_o       (ex_rec)
  );

  pipe_reg #(.payload_t(commit_t)) u_ex_wb (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (id_ex_valid),
    .ready_o (ex_wb_ready),
    .data_i  (ex_rec),
    .valid_o (commit_valid_o),
    .ready_i (commit_ready_i),
    .data_o  (commit_o)
  );

endmodule

/* int_pipeline_sva.sv */
`timescale 1ns/1ps

module int_pipeline_sva (
  input logic               clk_i,
  input logic               rst_i,
  input logic               commit_valid_i,
  input logic               commit_ready_i,
  input core_pkg::commit_t  commit_i,
  input logic               rf_we_i,
  input core_pkg::reg_idx_t rf_rd_i
);

  // Failure count, read by the testbench at the end of the run
  int sva_errors = 0;

  // Commit record must hold while the consumer stalls
  commit_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    commit_valid_i && !commit_ready_i |=> commit_valid_i && $stable(commit_i))
    else begin
      $error("commit record changed while stalled");
      sva_errors++;
    end

  // x0 has no storage, so no write may target it
  rf_x0_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rf_we_i |-> rf_rd_i != '0)
    else begin
      $error("register file written with rd zero");
      sva_errors++;
    end

  reset_empty_a: assert property (@(posedge clk_i)
    rst_i |=> !commit_valid_i)
    else begin
      $error("commit valid high in the cycle after reset");
      sva_errors++;
    end

endmodule

bind int_pipeline int_pipeline_sva u_int_pipeline_sva (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .commit_valid_i (commit_valid_o),
  .commit_ready_i (commit_ready_i),
  .commit_i       (commit_o),
  .rf_we_i        (rf_we),
  .rf_rd_i        (commit_o.rd)
);

/* tb_int_pipeline.sv */
`timescale 1ns/1ps

module tb_int_pipeline;
  import core_pkg::*;

  localparam int WAIT_LIMIT = 400;

  logic    clk_i;
  logic    rst_i;
  logic    in_valid_i;
  logic    in_ready_o;
  inst_t   in_inst_i;
  logic    commit_valid_o;
  logic    commit_ready_i;
  commit_t commit_o;

  word_t   model_regs [0:31];
  commit_t exp_q [$];
  int      error_count;
  int      check_count;
  int      test_count;
  bit      bp_mode;
  bit      gap_mode;

  int_pipeline u_int_pipeline (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .in_inst_i      (in_inst_i),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_o       (commit_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // ======================================================================
  // Reference model
  // ======================================================================

  // funct3 ops shared by OP and OP-IMM; returns 0 for unsupported funct3
  function automatic logic alu_ref(input logic [2:0] f3, input word_t a, input word_t b,
                                   output word_t y);
    y = '0;
    case (f3)
      3'b000:  y = a + b;
      3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  y = (a < b) ? 32'd1 : 32'd0;
      3'b100:  y = a ^ b;
      3'b110:  y = a | b;
      3'b111:  y = a & b;
      default: return 1'b0;
    endcase
    return 1'b1;
  endfunction

  function automatic commit_t predict(input inst_t inst);
    commit_t r;
    word_t   a;
    word_t   b;
    word_t   imm;
    word_t   y;
    logic    ok;
    a   = model_regs[inst[19:15]];
    b   = model_regs[inst[24:20]];
    imm = {{20{inst[31]}}, inst[31:20]};
    y   = '0;
    ok  = 1'b0;
    case (inst[6:0])
      7'h33: begin
        if (inst[31:25] == 7'h00) begin
          ok = alu_ref(inst[14:12], a, b, y);
        end else if (inst[31:25] == 7'h20 && inst[14:12] == 3'b000) begin
          y  = a - b;
          ok = 1'b1;
        end
      end
      7'h13: ok = alu_ref(inst[14:12], a, imm, y);
      7'h37: begin
        y  = {inst[31:12], 12'h000};
        ok = 1'b1;
      end
      default: ok = 1'b0;
    endcase
    r.rd      = inst[11:7];
    r.result  = y;
    r.we      = ok;
    r.illegal = !ok;
    return r;
  endfunction

  // ======================================================================
  // Instruction generation
  // ======================================================================

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [2:0] pick_f3(input int n);
    case (n)
      0:       return 3'b000;
      1:       return 3'b111;
      2:       return 3'b110;
      3:       return 3'b100;
      4:       return 3'b010;
      default: return 3'b011;
    endcase
  endfunction

  function automatic reg_idx_t rand_reg(input bit nonzero);
    if (nonzero) begin
      return reg_idx_t'(1 + $urandom % 31);
    end
    return reg_idx_t'($urandom);
  endfunction

  // R-type ops 0..6, I-type ops 7..12, LUI 13
  function automatic inst_t rand_legal(input reg_idx_t rd, input reg_idx_t rs1,
                                       input reg_idx_t rs2);
    int          k;
    logic [31:0] r;
    k = $urandom % 14;
    r = $urandom;
    if (k < 6) begin
      return enc_r(7'h00, pick_f3(k), rd, rs1, rs2);
    end else if (k == 6) begin
      return enc_r(7'h20, 3'b000, rd, rs1, rs2);
    end else if (k < 13) begin
      return enc_i(r[11:0], pick_f3(k - 7), rd, rs1);
    end
    return {r[19:0], rd, 7'h37};
  endfunction

  function automatic inst_t rand_illegal();
    logic [31:0] w;
    w = $urandom;
    case ($urandom % 3)
      0: begin
        if (w[6:0] == 7'h33 || w[6:0] == 7'h13 || w[6:0] == 7'h37) begin
          w[6:0] = 7'h0b;
        end
      end
      1:       w = enc_r(7'h01, w[14:12], w[11:7], w[19:15], w[24:20]);
      default: w = enc_i(w[31:20], 3'b001, w[11:7], w[19:15]);
    endcase
    return w;
  endfunction

  // ======================================================================
  // Driving and checking
  // ======================================================================

  task automatic abort_run(input string msg);
    $display("Timeout: %s", msg);
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count + 1);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic check_field(input string name, input word_t got, input word_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  // Inputs and commit_ready_i only change here
  task automatic tick();
    @(negedge clk_i);
    commit_ready_i = bp_mode ? ($urandom % 2 == 0) : 1'b1;
  endtask

  task automatic send_inst(input inst_t inst);
    int      gap;
    int      waited;
    commit_t exp;
    gap = gap_mode ? $urandom % 3 : 0;
    repeat (gap) begin
      tick();
      in_valid_i = 1'b0;
    end
    tick();
    in_valid_i = 1'b1;
    in_inst_i  = inst;
    waited     = 0;
    @(posedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("instruction never accepted by the pipeline");
      tick();
      @(posedge clk_i);
    end
    // Accepted on this edge, model updates in program order
    exp = predict(inst);
    exp_q.push_back(exp);
    if (exp.we && exp.rd != '0) model_regs[exp.rd] = exp.result;
  endtask

  task automatic drain();
    int waited;
    tick();
    in_valid_i = 1'b0;
    waited     = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("pipeline did not commit all instructions");
      tick();
    end
    check_field("commit_valid_o", word_t'(commit_valid_o), '0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("Test %0d %s: %0d errors", test_count, name, error_count - errs_before);
  endtask

  // Commit monitor
  always @(posedge clk_i) begin
    commit_t exp;
    if (!rst_i && commit_valid_o && commit_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected commit with no instruction outstanding");
        error_count++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        check_field("commit_o.rd", word_t'(commit_o.rd), word_t'(exp.rd));
        check_field("commit_o.we", word_t'(commit_o.we), word_t'(exp.we));
        check_field("commit_o.illegal", word_t'(commit_o.illegal), word_t'(exp.illegal));
        if (!exp.illegal) check_field("commit_o.result", commit_o.result, exp.result);
      end
    end
  end

  // ======================================================================
  // Tests
  // ======================================================================

  initial begin
    int       errs;
    reg_idx_t prev;
    reg_idx_t prev2;
    reg_idx_t rd;
    inst_t    bad;
    void'($urandom(81693));
    rst_i          = 1'b1;
    in_valid_i     = 1'b0;
    in_inst_i      = '0;
    commit_ready_i = 1'b1;
    bp_mode        = 1'b0;
    gap_mode       = 1'b0;
    error_count    = 0;
    check_count    = 0;
    test_count     = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (2) @(posedge clk_i);
    tick();
    rst_i = 1'b0;

    errs = error_count;
    check_field("commit_valid_o", word_t'(commit_valid_o), '0);
    check_field("in_ready_o", word_t'(in_ready_o), 32'd1);
    for (int i = 0; i < 32; i++) send_inst(enc_r(7'h00, 3'b000, reg_idx_t'(i), reg_idx_t'(i), '0));
    drain();
    report_test("reset", errs);

    errs = error_count;
    for (int i = 0; i < 200; i++) send_inst(rand_legal(rand_reg(0), rand_reg(0), rand_reg(0)));
    drain();
    report_test("random ALU stream", errs);

    // Each instruction reads the previous rd, sometimes the one before
    errs  = error_count;
    prev  = rand_reg(1);
    prev2 = rand_reg(1);
    for (int i = 0; i < 150; i++) begin
      rd = rand_reg(1);
      send_inst(rand_legal(rd, prev, ($urandom % 2) ? prev2 : prev));
      prev2 = prev;
      prev  = rd;
    end
    drain();
    report_test("forwarding", errs);

    errs     = error_count;
    bp_mode  = 1'b1;
    gap_mode = 1'b1;
    for (int i = 0; i < 200; i++) send_inst(rand_legal(rand_reg(0), rand_reg(0), rand_reg(0)));
    drain();
    bp_mode  = 1'b0;
    gap_mode = 1'b0;
    report_test("back-pressure", errs);

    // Read back the illegal rd right after each decode error
    errs = error_count;
    for (int i = 0; i < 80; i++) begin
      if ($urandom % 3 == 0) begin
        bad = rand_illegal();
        send_inst(bad);
        send_inst(enc_r(7'h00, 3'b000, rand_reg(1), bad[11:7], '0));
      end else begin
        send_inst(rand_legal(rand_reg(0), rand_reg(0), rand_reg(0)));
      end
    end
    drain();
    report_test("illegal instructions", errs);

    errs = error_count;
    for (int i = 0; i < 20; i++) begin
      send_inst(enc_i(12'($urandom), 3'b000, '0, rand_reg(0)));
      send_inst(enc_r(7'h00, 3'b110, '0, rand_reg(0), rand_reg(0)));
      send_inst(enc_r(7'h00, 3'b000, rand_reg(1), '0, '0));
    end
    drain();
    report_test("writes to x0", errs);

    // Failures of the bound concurrent assertions
    error_count += u_int_pipeline.u_int_pipeline_sva.sva_errors;

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
core_pkg.sv
inst_decoder.sv
reg_file.sv
pipe_reg.sv
exec_stage.sv
int_pipeline.sv
int_pipeline_sva.sv
tb_int_pipeline.sv
